//--- logic/a2e_bus_pkg.sv
// Bus level types for the IIe controller; RAM addresses keep their top two bits at zero
`default_nettype none

package a2e_bus_pkg;

    typedef logic [15:0] addr_t;        // CPU address
    typedef logic [7:0]  byte_t;
    typedef logic [17:0] ram_addr_t;    // Word address into the 16-bit RAM
    typedef logic [13:0] rom_addr_t;    // 16K internal ROM

    // ------------------------------
    // Decoded target of one access
    typedef enum logic [3:0] {
        REG_RAM,
        REG_KBD,            // C00x, key data and IIe switch writes
        REG_STATUS,         // C01x
        REG_TAPE,           // C02x
        REG_SPEAKER,        // C03x
        REG_KSTB,           // C04x
        REG_VIDSW,          // C05x
        REG_GAME,           // C06x
        REG_PDL,            // C07x
        REG_LCARD,          // C08x
        REG_DEV,            // C090-C0FF
        REG_SLOT_IO,
        REG_SLOT_STRB,
        REG_ROM
    } region_t;

    // Map constants
    localparam addr_t        C8_RELEASE_ADR = 16'hCFFF;
    localparam logic [7:0]   C3_PAGE        = 8'hC3;    // Slot 3 firmware page
    localparam logic [3:0]   D_PAGE_HI      = 4'hD;     // Banked 4K of the language card

endpackage

`default_nettype wire

//--- logic/a2e_switch_pkg.sv
// Soft switch and status offsets of the IIe; indices follow the address bits of C00x and C05x
`default_nettype none

package a2e_switch_pkg;

    // IIe switches, written at C00x with bits 3..1 as index
    localparam logic [2:0] SW_STORE80 = 3'd0;
    localparam logic [2:0] SW_RAMRD   = 3'd1;
    localparam logic [2:0] SW_RAMWRT  = 3'd2;
    localparam logic [2:0] SW_CXROM   = 3'd3;
    localparam logic [2:0] SW_ALTZP   = 3'd4;
    localparam logic [2:0] SW_C3ROM   = 3'd5;
    localparam logic [2:0] SW_COL80   = 3'd6;
    localparam logic [2:0] SW_ALTCHAR = 3'd7;

    // Video switches at C05x, 4-7 are annunciators
    localparam logic [2:0] VS_TEXT    = 3'd0;
    localparam logic [2:0] VS_MIXED   = 3'd1;
    localparam logic [2:0] VS_PAGE2   = 3'd2;
    localparam logic [2:0] VS_HIRES   = 3'd3;

    // ------------------------------
    // Status offsets within C01x
    localparam logic [3:0] ST_KEY     = 4'h0;
    localparam logic [3:0] ST_BANK2   = 4'h1;
    localparam logic [3:0] ST_LCRAM   = 4'h2;
    localparam logic [3:0] ST_RAMRD   = 4'h3;
    localparam logic [3:0] ST_RAMWRT  = 4'h4;
    localparam logic [3:0] ST_CXROM   = 4'h5;
    localparam logic [3:0] ST_ALTZP   = 4'h6;
    localparam logic [3:0] ST_C3ROM   = 4'h7;
    localparam logic [3:0] ST_STORE80 = 4'h8;
    localparam logic [3:0] ST_VBL     = 4'h9;
    localparam logic [3:0] ST_TEXT    = 4'hA;
    localparam logic [3:0] ST_MIXED   = 4'hB;
    localparam logic [3:0] ST_PAGE2   = 4'hC;
    localparam logic [3:0] ST_HIRES   = 4'hD;
    localparam logic [3:0] ST_ALTCHAR = 4'hE;
    localparam logic [3:0] ST_COL80   = 4'hF;

endpackage

`default_nettype wire

//--- logic/a2e_io_decode.sv
// Region is combinational from the held address and reads as plain RAM while the bus is idle
`default_nettype none

module a2e_io_decode (
    input  wire                   CLK_14M,
    input  wire                   reset,
    input  a2e_bus_pkg::addr_t    adr,
    input  wire                   cyc_stb,
    input  wire                   access,
    input  wire                   cxrom,
    input  wire                   c3rom,
    output a2e_bus_pkg::region_t  region,
    output logic [2:0]            slot
);
    import a2e_bus_pkg::*;

    logic c8rom;    // Internal ROM owns C800-CFFF

    // ------------------------------
    // Address map walk
    always_comb
    begin
        if (adr[15:14] != 2'b11)
            region = REG_RAM;                   // 0000-BFFF
        else if (adr[13:12] != 2'b00)
            region = REG_ROM;                   // D000-FFFF
        else if (adr[11:8] == 4'h0)
        begin
            case (adr[7:4])
                4'h0:    region = REG_KBD;
                4'h1:    region = REG_STATUS;
                4'h2:    region = REG_TAPE;
                4'h3:    region = REG_SPEAKER;
                4'h4:    region = REG_KSTB;
                4'h5:    region = REG_VIDSW;
                4'h6:    region = REG_GAME;
                4'h7:    region = REG_PDL;
                4'h8:    region = REG_LCARD;
                default: region = REG_DEV;
            endcase
        end
        else if (adr[11])
            region = (cxrom || c8rom) ? REG_ROM : REG_SLOT_STRB;
        else if (adr[11:8] == 4'h3)
            region = (cxrom || !c3rom) ? REG_ROM : REG_SLOT_IO;
        else
            region = cxrom ? REG_ROM : REG_SLOT_IO;

        // Idle bus strobes nothing
        if (!cyc_stb)
            region = REG_RAM;
    end

    // Device slots from bits 6..4 in page C0, card slots from bits 10..8
    assign slot = (adr[11:8] == 4'h0) ? adr[6:4] : adr[10:8];

    // ------------------------------
    // C8ROM latch
    always_ff @(posedge CLK_14M)
    begin
        if (reset)
            c8rom <= 1'b0;
        else if (access)
        begin
            if (adr[15:8] == C3_PAGE && !c3rom)
                c8rom <= 1'b1;                  // Slot 3 firmware claims C8xx
            else if (adr == C8_RELEASE_ADR)
                c8rom <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/a2e_soft_switches.sv
// Switch state changes only on the ack edge; status_bit shows the state before that edge
`default_nettype none

module a2e_soft_switches (
    input  wire                   CLK_14M,
    input  wire                   reset,
    input  wire                   access,
    input  wire                   we,
    input  wire  [3:0]            adr_low,
    input  a2e_bus_pkg::region_t  region,
    input  wire                   any_key,
    input  wire                   vbl,
    input  wire                   lc_bank1,
    input  wire                   lc_read,
    output logic [7:0]            iie_sw,
    output logic [7:0]            video_sw,
    output logic                  status_bit,
    output logic                  speaker,
    output logic                  read_key
);
    import a2e_bus_pkg::*;
    import a2e_switch_pkg::*;

    // ------------------------------
    // Switch registers
    always_ff @(posedge CLK_14M)
    begin
        if (reset)
        begin
            iie_sw   <= 8'h00;
            video_sw <= 8'h00;
            speaker  <= 1'b0;
            read_key <= 1'b0;
        end
        else
        begin
            // Key strobe clear on C010 read or any C01x write
            read_key <= access && region == REG_STATUS && (we || adr_low == ST_KEY);

            if (access && we && region == REG_KBD)
                iie_sw[adr_low[3:1]] <= adr_low[0];

            if (access && region == REG_VIDSW)
                video_sw[adr_low[3:1]] <= adr_low[0];   // Reads switch too

            if (access && region == REG_SPEAKER)
                speaker <= ~speaker;
        end
    end

    // ------------------------------
    // Status bit for C01x reads
    always_comb
    begin
        case (adr_low)
            ST_KEY:     status_bit = any_key;
            ST_BANK2:   status_bit = ~lc_bank1;
            ST_LCRAM:   status_bit = lc_read;
            ST_RAMRD:   status_bit = iie_sw[SW_RAMRD];
            ST_RAMWRT:  status_bit = iie_sw[SW_RAMWRT];
            ST_CXROM:   status_bit = iie_sw[SW_CXROM];
            ST_ALTZP:   status_bit = iie_sw[SW_ALTZP];
            ST_C3ROM:   status_bit = iie_sw[SW_C3ROM];
            ST_STORE80: status_bit = iie_sw[SW_STORE80];
            ST_VBL:     status_bit = ~vbl;          // High outside blanking
            ST_TEXT:    status_bit = video_sw[VS_TEXT];
            ST_MIXED:   status_bit = video_sw[VS_MIXED];
            ST_PAGE2:   status_bit = video_sw[VS_PAGE2];
            ST_HIRES:   status_bit = video_sw[VS_HIRES];
            ST_ALTCHAR: status_bit = iie_sw[SW_ALTCHAR];
            ST_COL80:   status_bit = iie_sw[SW_COL80];
            default:    status_bit = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/a2e_mem_map.sv
// Language card leaves reset with bank 2, ROM read and RAM write enabled, as on the IIe
`default_nettype none

module a2e_mem_map (
    input  wire                     CLK_14M,
    input  wire                     reset,
    input  wire                     access,
    input  wire                     cyc_stb,
    input  wire                     we,
    input  a2e_bus_pkg::addr_t      adr,
    input  a2e_bus_pkg::region_t    region,
    input  wire  [7:0]              iie_sw,
    input  wire  [7:0]              video_sw,
    output logic                    lc_bank1,
    output logic                    lc_read,
    output logic                    lc_read_en,
    output a2e_bus_pkg::ram_addr_t  ram_addr,
    output logic                    ram_aux,
    output logic                    ram_we
);
    import a2e_bus_pkg::*;
    import a2e_switch_pkg::*;

    logic lc_pre_wr;    // First of two odd reads seen
    logic lc_wr_n;
    logic hi_ram;       // D000-FFFF
    logic dxxx;
    logic lc_write_en;
    logic rd_wr_aux;    // Aux choice from RAMRD or RAMWRT

    // ------------------------------
    // Language card state
    always_ff @(posedge CLK_14M)
    begin
        if (reset)
        begin
            lc_bank1  <= 1'b0;
            lc_read   <= 1'b0;
            lc_pre_wr <= 1'b0;
            lc_wr_n   <= 1'b0;
        end
        else if (access && region == REG_LCARD)
        begin
            lc_bank1  <= adr[3];
            lc_pre_wr <= adr[0] & ~we;
            if (lc_pre_wr && !we && adr[0])
                lc_wr_n <= 1'b0;
            else if (!adr[0])
                lc_wr_n <= 1'b1;
            lc_read   <= ~(adr[0] ^ adr[1]);
        end
    end

    assign hi_ram      = (region == REG_ROM) && (adr[15:12] >= D_PAGE_HI);
    assign dxxx        = (adr[15:12] == D_PAGE_HI);
    assign lc_read_en  = lc_read & hi_ram;
    assign lc_write_en = ~lc_wr_n & hi_ram;

    // Bank 1 sits at C000-CFFF of the RAM
    assign ram_addr = cyc_stb ?
                      {2'b00, adr[15:13], adr[12] & ~(lc_bank1 & dxxx), adr[11:0]} :
                      '0;

    assign ram_we = access & we & ((region == REG_RAM) | lc_write_en);

    // ------------------------------
    // Main or aux lane
    assign rd_wr_aux = we ? iie_sw[SW_RAMWRT] : iie_sw[SW_RAMRD];

    always_comb
    begin
        if (adr[15:9] == 7'b0000000 || adr[15:14] == 2'b11)
            ram_aux = iie_sw[SW_ALTZP];             // Pages 00-01, C0-FF
        else if (adr[15:10] == 6'b000001)           // Text page 1
            ram_aux = iie_sw[SW_STORE80] ? video_sw[VS_PAGE2] : rd_wr_aux;
        else if (adr[15:13] == 3'b001)              // Hires page 1
            ram_aux = (iie_sw[SW_STORE80] && video_sw[VS_HIRES]) ?
                      video_sw[VS_PAGE2] : rd_wr_aux;
        else
            ram_aux = rd_wr_aux;
    end

endmodule

`default_nettype wire

//--- logic/a2e_io_core.sv
// Wishbone classic slave with one wait state; RAM and ROM must return data one cycle after address
`default_nettype none

module a2e_io_core (
    input  wire                     CLK_14M,
    input  wire                     reset,
    // Wishbone slave
    input  wire                     wb_cyc,
    input  wire                     wb_stb,
    input  wire                     wb_we,
    input  a2e_bus_pkg::addr_t      wb_adr,
    input  a2e_bus_pkg::byte_t      wb_dat_w,
    output a2e_bus_pkg::byte_t      wb_dat_r,
    output logic                    wb_ack,
    // External RAM, low byte main and high byte aux
    output a2e_bus_pkg::ram_addr_t  ram_addr,
    output a2e_bus_pkg::byte_t      ram_dat_w,
    output logic                    ram_we,
    output logic                    ram_aux,
    input  wire  [15:0]             ram_do,
    output a2e_bus_pkg::rom_addr_t  rom_addr,
    input  a2e_bus_pkg::byte_t      rom_data,
    // Keyboard
    input  a2e_bus_pkg::byte_t      key_data,
    input  wire                     any_key,
    output logic                    read_key,
    input  wire  [7:0]              game_in,
    input  wire                     vbl,
    input  a2e_bus_pkg::byte_t      periph_data,
    output logic [7:0]              io_select,
    output logic [7:0]              dev_select,
    output logic                    io_strobe,
    output logic                    pdl_strobe,
    output logic                    kbd_strobe,
    output logic [3:0]              annunciator,
    output logic [3:0]              video_mode,
    output logic                    col80,
    output logic                    altchar,
    output logic                    speaker
);
    import a2e_bus_pkg::*;
    import a2e_switch_pkg::*;

    logic    cyc_stb;
    logic    access;     // Last cycle of an access
    region_t region;
    logic [2:0] slot;
    logic [7:0] iie_sw;
    logic [7:0] video_sw;
    logic    status_bit;
    logic    lc_bank1;
    logic    lc_read;
    logic    lc_read_en;
    byte_t   ram_byte;
    logic    floating;

    assign cyc_stb = wb_cyc & wb_stb;
    assign access  = cyc_stb & wb_ack;

    // ------------------------------
    // Handshake
    always_ff @(posedge CLK_14M)
    begin
        if (reset)
            wb_ack <= 1'b0;
        else
            wb_ack <= cyc_stb & ~wb_ack;    // Single cycle ack
    end

    a2e_io_decode u_decode (
        .CLK_14M (CLK_14M),
        .reset   (reset),
        .adr     (wb_adr),
        .cyc_stb (cyc_stb),
        .access  (access),
        .cxrom   (iie_sw[SW_CXROM]),
        .c3rom   (iie_sw[SW_C3ROM]),
        .region  (region),
        .slot    (slot)
    );

    a2e_soft_switches u_switches (
        .CLK_14M    (CLK_14M),
        .reset      (reset),
        .access     (access),
        .we         (wb_we),
        .adr_low    (wb_adr[3:0]),
        .region     (region),
        .any_key    (any_key),
        .vbl        (vbl),
        .lc_bank1   (lc_bank1),
        .lc_read    (lc_read),
        .iie_sw     (iie_sw),
        .video_sw   (video_sw),
        .status_bit (status_bit),
        .speaker    (speaker),
        .read_key   (read_key)
    );

    a2e_mem_map u_mem_map (
        .CLK_14M    (CLK_14M),
        .reset      (reset),
        .access     (access),
        .cyc_stb    (cyc_stb),
        .we         (wb_we),
        .adr        (wb_adr),
        .region     (region),
        .iie_sw     (iie_sw),
        .video_sw   (video_sw),
        .lc_bank1   (lc_bank1),
        .lc_read    (lc_read),
        .lc_read_en (lc_read_en),
        .ram_addr   (ram_addr),
        .ram_aux    (ram_aux),
        .ram_we     (ram_we)
    );

    assign ram_dat_w = wb_dat_w;
    assign rom_addr  = cyc_stb ? wb_adr[13:0] : '0;
    assign ram_byte  = ram_aux ? ram_do[15:8] : ram_do[7:0];

    // Switch pages with nothing to drive, video data is not modelled
    assign floating = (region == REG_TAPE) || (region == REG_SPEAKER) ||
                      (region == REG_KSTB) || (region == REG_VIDSW) ||
                      (region == REG_PDL) || (region == REG_LCARD) ||
                      (wb_adr == C8_RELEASE_ADR);

    // ------------------------------
    // Read data in priority order
    always_comb
    begin
        if (region == REG_RAM || lc_read_en)
            wb_dat_r = ram_byte;
        else if (region == REG_KBD)
            wb_dat_r = key_data;
        else if (region == REG_STATUS)
            wb_dat_r = {status_bit, key_data[6:0]};
        else if (region == REG_GAME)
            wb_dat_r = {game_in[wb_adr[2:0]], 7'b0000000};
        else if (region == REG_ROM)
            wb_dat_r = rom_data;
        else if (floating)
            wb_dat_r = 8'h00;
        else
            wb_dat_r = periph_data;
    end

    // Region already reads RAM on an idle bus, so selects stay low
    assign io_select  = (region == REG_SLOT_IO) ? (8'h01 << slot) : 8'h00;
    assign dev_select = (region == REG_DEV) ? (8'h01 << slot) : 8'h00;
    assign io_strobe  = (region == REG_SLOT_STRB);
    assign pdl_strobe = (region == REG_PDL);
    assign kbd_strobe = (region == REG_KSTB);

    assign video_mode  = video_sw[3:0];
    assign annunciator = video_sw[7:4];
    assign col80       = iie_sw[SW_COL80];
    assign altchar     = iie_sw[SW_ALTCHAR];

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
// Free running clock of period 40 with a synchronous reset held for the first 4 cycles
`default_nettype none

module tb_clock (
    output logic CLK_14M,
    output logic reset
);
    initial
    begin
        CLK_14M = 1'b0;
        forever #20 CLK_14M = ~CLK_14M;
    end

    initial
    begin
        reset = 1'b1;
        repeat (4) @(posedge CLK_14M);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- dv/a2e_ram_model.sv
// RAM and ROM return data one clock after the address; only the low 16 RAM address bits are used
`default_nettype none

module a2e_ram_model (
    input  wire         CLK_14M,
    input  wire  [17:0] ram_addr,
    input  wire  [7:0]  ram_dat_w,
    input  wire         ram_we,
    input  wire         ram_aux,
    output logic [15:0] ram_do,
    input  wire  [13:0] rom_addr,
    output logic [7:0]  rom_data
);
    logic [15:0] mem [0:65535];     // Low byte main, high byte aux
    logic [7:0]  rom [0:16383];

    initial
    begin
        ram_do   = 16'h0000;
        rom_data = 8'h00;
        for (int i = 0; i < 65536; i++)
            mem[i] = {~(i[7:0] ^ i[15:8]), i[7:0] ^ i[15:8]};   // Aux lane inverted
        for (int i = 0; i < 16384; i++)
            rom[i] = i[7:0] ^ {2'b00, i[13:8]};    // Depends on every address bit
    end

    always @(posedge CLK_14M)
    begin
        if (ram_we && ram_aux)
            mem[ram_addr[15:0]][15:8] <= ram_dat_w;
        else if (ram_we)
            mem[ram_addr[15:0]][7:0] <= ram_dat_w;
        ram_do   <= mem[ram_addr[15:0]];
        rom_data <= rom[rom_addr];
    end

endmodule

`default_nettype wire

//--- dv/a2e_io_core_props.sv
// Handshake and RAM write checks for the Wishbone slave; inactive while reset is high
`default_nettype none

module a2e_io_core_props (
    input wire        CLK_14M,
    input wire        reset,
    input wire        wb_cyc,
    input wire        wb_stb,
    input wire        wb_we,
    input wire [15:0] wb_adr,
    input wire        wb_ack,
    input wire        ram_we
);
    // Ack one cycle after a new request
    assert property (@(posedge CLK_14M) disable iff (reset)
        (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
        else $error("ack missing one cycle after stb");

    assert property (@(posedge CLK_14M) disable iff (reset)
        wb_ack |=> !wb_ack)
        else $error("ack longer than one cycle");

    // RAM writes only in the ack of a held write, never into C000-CFFF
    assert property (@(posedge CLK_14M) disable iff (reset)
        ram_we |-> (wb_ack && wb_we && $past(wb_cyc && wb_stb && wb_we) &&
                    (wb_adr < 16'hC000 || wb_adr >= 16'hD000)))
        else $error("RAM write outside the ack cycle of a RAM write");

endmodule

bind a2e_io_core a2e_io_core_props u_props (.*);

`default_nettype wire

//--- dv/tb_a2e.sv
// Drives the controller over Wishbone; RAM model holds an address pattern until written, any_key and vbl flip before the last status sweep
`default_nettype none

module tb_a2e;
    import a2e_bus_pkg::*;
    import a2e_switch_pkg::*;

    localparam int TIMEOUT_CYCLES = 3000;   // ~420 accesses of 3 cycles plus margin

    logic CLK_14M, reset;
    logic wb_cyc, wb_stb, wb_we, wb_ack, ram_we, ram_aux, any_key, read_key, vbl;
    addr_t wb_adr;
    byte_t wb_dat_w, wb_dat_r, ram_dat_w, rom_data, key_data, periph_data;
    ram_addr_t ram_addr;
    rom_addr_t rom_addr;
    logic [15:0] ram_do;
    logic [7:0] game_in, io_select, dev_select;
    logic io_strobe, pdl_strobe, kbd_strobe, col80, altchar, speaker;
    logic [3:0] annunciator, video_mode;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    integer seed = 41484;
    byte_t exp_rd;
    byte_t exp_mem [int];       // Keyed by {aux, mapped address}
    logic [7:0] sh_sw, sh_vs;
    logic sh_spk, sh_bank1, sh_read, sh_pre, sh_wr_n, sh_c8rom;
    byte_t d0, d1;

    tb_clock u_clock (.CLK_14M(CLK_14M), .reset(reset));

    a2e_io_core u_dut (.*);

    a2e_ram_model u_mem (.CLK_14M(CLK_14M), .ram_addr(ram_addr), .ram_dat_w(ram_dat_w),
        .ram_we(ram_we), .ram_aux(ram_aux), .ram_do(ram_do), .rom_addr(rom_addr),
        .rom_data(rom_data));

    function automatic byte_t rom_pattern(logic [13:0] a);
        return a[7:0] ^ {2'b00, a[13:8]};
    endfunction

    // Power-up RAM contents of the model for a {aux, address} key
    function automatic byte_t fill_of(int k);
        byte_t f;
        f = k[7:0] ^ k[15:8];
        return k[16] ? ~f : f;
    endfunction

    function automatic logic aux_of(addr_t a, logic we);
        logic rw;
        rw = we ? sh_sw[SW_RAMWRT] : sh_sw[SW_RAMRD];
        if (a < 16'h0200 || a >= 16'hC000)
            return sh_sw[SW_ALTZP];
        if (a >= 16'h0400 && a < 16'h0800)
            return sh_sw[SW_STORE80] ? sh_vs[VS_PAGE2] : rw;
        if (a >= 16'h2000 && a < 16'h4000)
            return (sh_sw[SW_STORE80] && sh_vs[VS_HIRES]) ? sh_vs[VS_PAGE2] : rw;
        return rw;
    endfunction

    function automatic int mem_key(addr_t a, logic we);
        addr_t m;
        m = (sh_bank1 && a[15:12] == 4'hD) ? (a & 16'hEFFF) : a;   // Bank 1 at Cxxx
        return {15'd0, aux_of(a, we), m};
    endfunction

    function automatic logic status_of(logic [3:0] o);
        case (o)
            ST_KEY:   return any_key;
            ST_BANK2: return ~sh_bank1;
            ST_LCRAM: return sh_read;
            ST_RAMRD: return sh_sw[SW_RAMRD];
            ST_RAMWRT: return sh_sw[SW_RAMWRT];
            ST_CXROM: return sh_sw[SW_CXROM];
            ST_ALTZP: return sh_sw[SW_ALTZP];
            ST_C3ROM: return sh_sw[SW_C3ROM];
            ST_STORE80: return sh_sw[SW_STORE80];
            ST_VBL:   return ~vbl;
            ST_TEXT:  return sh_vs[VS_TEXT];
            ST_MIXED: return sh_vs[VS_MIXED];
            ST_PAGE2: return sh_vs[VS_PAGE2];
            ST_HIRES: return sh_vs[VS_HIRES];
            ST_ALTCHAR: return sh_sw[SW_ALTCHAR];
            default:  return sh_sw[SW_COL80];
        endcase
    endfunction

    // Reference read byte from the shadow state before the access
    function automatic byte_t expected_read(addr_t a);
        int k;
        k = mem_key(a, 1'b0);
        if (a < 16'hC000 || (a >= 16'hD000 && sh_read))
            return exp_mem.exists(k) ? exp_mem[k] : fill_of(k);
        if (a >= 16'hD000)
            return rom_pattern(a[13:0]);
        if (a[11:8] == 4'h0)
        begin
            case (a[7:4])
                4'h0: return key_data;
                4'h1: return {status_of(a[3:0]), key_data[6:0]};
                4'h6: return {game_in[a[2:0]], 7'd0};
                4'h2, 4'h3, 4'h4, 4'h5, 4'h7, 4'h8: return 8'h00;
                default: return periph_data;
            endcase
        end
        if (a[11])
        begin
            if (sh_sw[SW_CXROM] || sh_c8rom)
                return rom_pattern(a[13:0]);
            return (a == C8_RELEASE_ADR) ? 8'h00 : periph_data;
        end
        if (sh_sw[SW_CXROM] || (a[11:8] == 4'h3 && !sh_sw[SW_C3ROM]))
            return rom_pattern(a[13:0]);
        return periph_data;
    endfunction

    // Expected {io_select, dev_select, io_strobe, pdl_strobe, kbd_strobe} during an access
    function automatic logic [18:0] selects_of(addr_t a);
        logic [7:0] io_sel;
        logic [7:0] dev_sel;
        logic       strb;
        io_sel  = 8'h00;
        dev_sel = 8'h00;
        strb    = 1'b0;
        if (a[15:12] == 4'hC && a[11:8] == 4'h0 && a[7:4] >= 4'h9)
            dev_sel[a[6:4]] = 1'b1;
        else if (a[15:12] == 4'hC && a[11])
            strb = !(sh_sw[SW_CXROM] || sh_c8rom);
        else if (a[15:12] == 4'hC && a[11:8] != 4'h0 && !sh_sw[SW_CXROM] &&
                 (a[11:8] != 4'h3 || sh_sw[SW_C3ROM]))
            io_sel[a[10:8]] = 1'b1;
        return {io_sel, dev_sel, strb, a[15:4] == 12'hC07, a[15:4] == 12'hC04};
    endfunction

    // Shadow update at the end of the ack cycle
    task automatic apply_access(addr_t a, logic we, byte_t d);
        if (we && (a < 16'hC000 || (a >= 16'hD000 && !sh_wr_n)))
            exp_mem[mem_key(a, 1'b1)] = d;
        if (a[15:8] == C3_PAGE && !sh_sw[SW_C3ROM])
            sh_c8rom = 1'b1;
        else if (a == C8_RELEASE_ADR)
            sh_c8rom = 1'b0;
        if (a[15:4] == 12'hC00 && we)
            sh_sw[a[3:1]] = a[0];
        if (a[15:4] == 12'hC05)
            sh_vs[a[3:1]] = a[0];
        if (a[15:4] == 12'hC03)
            sh_spk = ~sh_spk;
        if (a[15:4] == 12'hC08)
        begin
            sh_bank1 = a[3];
            if (sh_pre && !we && a[0])
                sh_wr_n = 1'b0;
            else if (!a[0])
                sh_wr_n = 1'b1;
            sh_pre  = a[0] & ~we;
            sh_read = (a[0] == a[1]);
        end
    endtask

    task automatic check_value(string name, logic [7:0] got, logic [7:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // One Wishbone classic access, outputs checked after it ends
    task automatic bus_access(addr_t a, logic we, byte_t d);
        logic [18:0] seen_sel;
        logic [18:0] exp_sel;
        @(posedge CLK_14M);
        exp_rd   = expected_read(a);
        exp_sel  = selects_of(a);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= a;
        wb_dat_w <= d;
        do
        begin
            @(negedge CLK_14M);
            seen_sel = {io_select, dev_select, io_strobe, pdl_strobe, kbd_strobe};
        end
        while (!wb_ack);
        check_value("io_select", seen_sel[18:11], exp_sel[18:11]);
        check_value("dev_select", seen_sel[10:3], exp_sel[10:3]);
        check_value("io_strobe, pdl_strobe, kbd_strobe", {5'd0, seen_sel[2:0]},
                    {5'd0, exp_sel[2:0]});
        @(posedge CLK_14M);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        apply_access(a, we, d);
        @(negedge CLK_14M);
        check_value("read_key", {7'd0, read_key},
                    {7'd0, a[15:4] == 12'hC01 && (we || a[3:0] == 4'h0)});
        check_value("io_select", io_select, 8'h00);     // Idle bus
        check_value("dev_select", dev_select, 8'h00);
        check_value("io_strobe, pdl_strobe, kbd_strobe",
                    {5'd0, io_strobe, pdl_strobe, kbd_strobe}, 8'h00);
        check_value("video_mode", {4'd0, video_mode}, {4'd0, sh_vs[3:0]});
        check_value("annunciator", {4'd0, annunciator}, {4'd0, sh_vs[7:4]});
        check_value("speaker", {7'd0, speaker}, {7'd0, sh_spk});
        check_value("col80", {7'd0, col80}, {7'd0, sh_sw[SW_COL80]});
        check_value("altchar", {7'd0, altchar}, {7'd0, sh_sw[SW_ALTCHAR]});
    endtask

    // Read data comparison in every read ack cycle
    always @(negedge CLK_14M)
    begin
        if (wb_ack && wb_cyc && wb_stb && !wb_we)
            check_value("wb_dat_r", wb_dat_r, exp_rd);
    end

    always @(posedge CLK_14M)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, the run did not complete", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial
    begin
        {wb_cyc, wb_stb, wb_we} = 3'b000;
        wb_adr = '0;
        wb_dat_w = '0;
        any_key = 1'b1;
        vbl = 1'b0;
        key_data = 8'hC1;
        periph_data = 8'h5A;
        game_in = 8'hA6;
        {sh_sw, sh_vs} = 16'h0000;
        {sh_spk, sh_bank1, sh_read, sh_pre, sh_wr_n, sh_c8rom} = 6'd0;
        @(negedge reset);

        // ---------- Main and aux RAM ----------
        for (int i = 0; i < 24; i++)
        begin
            d0 = $random(seed);
            bus_access(addr_t'(i * 16'h0805 + 16'h0011), 1'b1, d0);
        end
        for (int i = 0; i < 24; i++)
            bus_access(addr_t'(i * 16'h0805 + 16'h0011), 1'b0, 8'h00);
        bus_access(16'hC003, 1'b1, 8'h00);
        bus_access(16'hC005, 1'b1, 8'h00);
        bus_access(16'h0811, 1'b1, 8'h3C);
        bus_access(16'h4816, 1'b1, 8'hC3);
        bus_access(16'h0811, 1'b0, 8'h00);
        bus_access(16'h0100, 1'b1, 8'h77);      // Main, ALTZP clear
        bus_access(16'hC002, 1'b1, 8'h00);
        bus_access(16'hC004, 1'b1, 8'h00);
        bus_access(16'h0811, 1'b0, 8'h00);
        bus_access(16'h4816, 1'b0, 8'h00);
        bus_access(16'hC009, 1'b1, 8'h00);
        bus_access(16'h0100, 1'b1, 8'h88);
        bus_access(16'h0100, 1'b0, 8'h00);
        bus_access(16'h0811, 1'b0, 8'h00);
        bus_access(16'hC008, 1'b1, 8'h00);
        bus_access(16'h0100, 1'b0, 8'h00);

        // ---------- IIe switches and status ----------
        for (int i = 0; i < 16; i++)
        begin
            bus_access(addr_t'(16'hC000 + i), 1'b1, 8'h00);
            for (int j = 0; j < 16; j++)
                bus_access(addr_t'(16'hC010 + j), 1'b0, 8'h00);
        end
        for (int i = 0; i < 16; i += 2)
            bus_access(addr_t'(16'hC000 + i), 1'b1, 8'h00);
        bus_access(16'hC000, 1'b0, 8'h00);
        bus_access(16'hC010, 1'b0, 8'h00);

        // ---------- Language card ----------
        d0 = $random(seed);
        d1 = $random(seed);
        bus_access(16'hC08B, 1'b0, 8'h00);
        bus_access(16'hC08B, 1'b0, 8'h00);
        bus_access(16'hD000, 1'b1, d0);
        bus_access(16'hD000, 1'b0, 8'h00);
        bus_access(16'hC083, 1'b0, 8'h00);
        bus_access(16'hC083, 1'b0, 8'h00);
        bus_access(16'hD000, 1'b1, d1);
        bus_access(16'hD000, 1'b0, 8'h00);
        bus_access(16'hC08B, 1'b0, 8'h00);
        bus_access(16'hD000, 1'b0, 8'h00);
        bus_access(16'hC011, 1'b0, 8'h00);     // Bank 1 and RAM read in status
        bus_access(16'hC012, 1'b0, 8'h00);
        bus_access(16'hC08A, 1'b0, 8'h00);     // Read and write off
        bus_access(16'hD000, 1'b0, 8'h00);
        bus_access(16'hE123, 1'b0, 8'h00);

        // ---------- Slot decoding ----------
        bus_access(16'hC100, 1'b0, 8'h00);
        bus_access(16'hC007, 1'b1, 8'h00);
        bus_access(16'hC100, 1'b0, 8'h00);
        bus_access(16'hC006, 1'b1, 8'h00);
        bus_access(16'hC300, 1'b0, 8'h00);
        bus_access(16'hC800, 1'b0, 8'h00);
        bus_access(C8_RELEASE_ADR, 1'b0, 8'h00);
        bus_access(16'hC800, 1'b0, 8'h00);
        bus_access(16'hC040, 1'b0, 8'h00);
        bus_access(16'hC070, 1'b0, 8'h00);
        for (int i = 1; i < 8; i++)
            bus_access(addr_t'(16'hC080 + i * 16), 1'b0, 8'h00);   // Device selects

        // ---------- Video, speaker, game ----------
        for (int i = 0; i < 16; i++)
            bus_access(addr_t'(16'hC050 + i), i[0], 8'h00);
        for (int i = 0; i < 5; i++)
            bus_access(16'hC030, 1'b0, 8'h00);
        for (int i = 0; i < 8; i++)
            bus_access(addr_t'(16'hC060 + i), 1'b0, 8'h00);

        // Status again with video switches set and key and blanking flipped
        @(posedge CLK_14M);
        any_key <= 1'b0;
        vbl     <= 1'b1;
        for (int j = 0; j < 16; j++)
            bus_access(addr_t'(16'hC010 + j), 1'b0, 8'h00);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
logic/a2e_bus_pkg.sv
logic/a2e_switch_pkg.sv
logic/a2e_io_decode.sv
logic/a2e_soft_switches.sv
logic/a2e_mem_map.sv
logic/a2e_io_core.sv
dv/tb_clock.sv
dv/a2e_ram_model.sv
dv/a2e_io_core_props.sv
dv/tb_a2e.sv

//--- Makefile
TOP = tb_a2e

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -o Vtb
	./obj_dir/Vtb | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
